// ==== verilog/icache_pkg.sv ====
// address and line widths, refill bus payload structs, miss controller state enum
package icache_pkg;

    // byte address of a fetch
    localparam int addr_w = 32;

    // one cache line is four 32-bit instruction words
    localparam int line_bytes = 16;
    localparam int off_w = $clog2(line_bytes);
    localparam int words_per_line = line_bytes / 4;
    localparam int line_w = line_bytes * 8;

    // request payload, the line address with the byte offset dropped
    typedef struct packed {
        logic [addr_w-off_w-1:0] line_addr;
    } refill_req_t;

    // response payload, word 0 in the low bits holds the lowest address
    typedef struct packed {
        logic [line_w-1:0] data;
    } refill_rsp_t;

    // ready_st answers hits directly
    // req_st holds the request until the bus takes it
    // wait_st waits for the refill line
    typedef enum logic [1:0] {
        ready_st = 2'd0,
        req_st   = 2'd1,
        wait_st  = 2'd2
    } ctrl_state_e;

endpackage

// ==== verilog/icache_array.sv ====
// two-way instruction cache storage with per-set LRU, hit detection and word extraction
`timescale 1ns/1ps

module icache_array #(
    parameter int sets = 64
) (
    input  logic                                         clk,
    input  logic                                         rst,
    input  logic [icache_pkg::addr_w-1:0]                lookup_pc,
    input  logic                                         lookup_en,
    input  logic                                         wr_en,
    input  logic [icache_pkg::addr_w-1:0]                wr_pc,
    input  logic                                         wr_way,
    input  icache_pkg::refill_rsp_t                      wr_line,
    output logic                                         hit,
    output logic                                         lru_way,
    output logic [icache_pkg::words_per_line-1:0][31:0]  inst,
    output logic [2:0]                                   inst_size
);
    import icache_pkg::*;

    localparam int idx_w = $clog2(sets);
    localparam int tag_w = addr_w - off_w - idx_w;
    localparam int wofs_w = off_w - 2;

    // storage, one entry per way and set
    logic [tag_w-1:0]       tag_mem  [2][sets];
    logic [line_w-1:0]      data_mem [2][sets];
    logic [1:0][sets-1:0]   valid_q;
    // lru_q holds the way to replace next
    logic [sets-1:0]        lru_q;

    logic [idx_w-1:0]       lk_idx;
    logic [tag_w-1:0]       lk_tag;
    logic [wofs_w-1:0]      lk_wofs;
    logic [idx_w-1:0]       wr_idx;
    logic [tag_w-1:0]       wr_tag;
    logic [1:0]             way_hit;
    logic                   hit_way;
    logic [line_w-1:0]      hit_line;

    // address split for lookup and refill
    assign lk_idx  = lookup_pc[off_w +: idx_w];
    assign lk_tag  = lookup_pc[addr_w-1 -: tag_w];
    assign lk_wofs = lookup_pc[off_w-1:2];
    assign wr_idx  = wr_pc[off_w +: idx_w];
    assign wr_tag  = wr_pc[addr_w-1 -: tag_w];

    // tag compare in both ways
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            way_hit[w] = valid_q[w][lk_idx] && (tag_mem[w][lk_idx] == lk_tag);
        end
    end

    assign hit      = |way_hit;
    assign hit_way  = way_hit[1];
    assign lru_way  = lru_q[lk_idx];
    assign hit_line = data_mem[hit_way][lk_idx];

    // shift the line so the word at pc lands in slot 0
    always_comb begin
        int src;
        inst = '0;
        for (int i = 0; i < words_per_line; i++) begin
            src = i + int'(lk_wofs);
            if (hit && (src < words_per_line)) begin
                inst[i] = hit_line[src*32 +: 32];
            end
        end
        inst_size = 3'(words_per_line - int'(lk_wofs));
    end

    // valid and replacement state
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            lru_q   <= '0;
        end else begin
            if (wr_en) begin
                valid_q[wr_way][wr_idx] <= 1'b1;
                lru_q[wr_idx]           <= ~wr_way;
            end else if (lookup_en && hit) begin
                // the way just used becomes most recent
                lru_q[lk_idx] <= ~hit_way;
            end
        end
    end

    // line fill into the chosen way
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_idx]  <= wr_tag;
            data_mem[wr_way][wr_idx] <= wr_line.data;
        end
    end

    // the controller never looks up and refills the same set in one cycle
    a_no_wr_hit_clash: assert property (
        @(posedge clk) disable iff (!rst)
        !(wr_en && lookup_en && hit && (lk_idx == wr_idx))
    ) else $error("refill and lookup hit on the same set in one cycle");

endmodule

// ==== verilog/icache_ctrl.sv ====
// per-hart miss FSM, refill request generation and array write control
`timescale 1ns/1ps

module icache_ctrl #(
    parameter int sets = 64
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           rena,
    input  logic [icache_pkg::addr_w-1:0]  pc,
    input  logic                           hit,
    input  logic                           lru_way,
    input  logic                           req_ready,
    input  logic                           rsp_valid,
    input  icache_pkg::refill_rsp_t        rsp,
    output logic                           rdone,
    output logic                           stall,
    output logic                           lookup_en,
    output logic                           wr_en,
    output logic [icache_pkg::addr_w-1:0]  wr_pc,
    output logic                           wr_way,
    output icache_pkg::refill_rsp_t        wr_line,
    output logic                           req_valid,
    output icache_pkg::refill_req_t        req,
    output logic                           rsp_ready
);
    import icache_pkg::*;

    localparam int idx_w = $clog2(sets);
    localparam int tag_w = addr_w - off_w - idx_w;

    ctrl_state_e       state_q;
    ctrl_state_e       state_d;
    logic              miss;
    // line being refilled, kept as tag and set
    logic [tag_w-1:0]  miss_tag;
    logic [idx_w-1:0]  miss_idx;
    logic              miss_way;

    assign miss = (state_q == ready_st) && rena && !hit;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q <= ready_st;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ready_st: begin
                if (miss) begin
                    state_d = req_st;
                end
            end
            req_st: begin
                // request taken by the bus
                if (req_ready) begin
                    state_d = wait_st;
                end
            end
            wait_st: begin
                if (rsp_valid) begin
                    state_d = ready_st;
                end
            end
            default: state_d = ready_st;
        endcase
    end

    // capture the missing line and its victim way
    always_ff @(posedge clk) begin
        if (miss) begin
            miss_tag <= pc[addr_w-1 -: tag_w];
            miss_idx <= pc[off_w +: idx_w];
            miss_way <= lru_way;
        end
    end

    // fetch side
    assign lookup_en = rena && (state_q == ready_st);
    assign rdone     = lookup_en && hit;
    assign stall     = (state_q != ready_st) || miss;

    // refill bus side
    assign req_valid      = (state_q == req_st);
    assign req.line_addr  = {miss_tag, miss_idx};
    assign rsp_ready      = (state_q == wait_st);

    // array write in the response cycle
    assign wr_en   = (state_q == wait_st) && rsp_valid;
    assign wr_pc   = {miss_tag, miss_idx, {off_w{1'b0}}};
    assign wr_way  = miss_way;
    assign wr_line = rsp;

    // a pending request holds its line address
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst)
        (req_valid && !req_ready) |=> (req_valid && $stable(req))
    ) else $error("refill request changed before transfer");

    // the arbiter only routes a response to the owner waiting for it
    a_rsp_in_wait: assert property (
        @(posedge clk) disable iff (!rst)
        rsp_valid |-> (state_q == wait_st)
    ) else $error("refill response outside wait state");

endmodule

// ==== verilog/refill_arbiter.sv ====
// round-robin arbiter for the shared line refill bus, one refill outstanding
`timescale 1ns/1ps

module refill_arbiter (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [1:0]                          req_valid,
    input  icache_pkg::refill_req_t [1:0]       req,
    input  logic [1:0]                          rsp_ready,
    input  logic                                bus_req_ready,
    input  logic                                bus_rsp_valid,
    input  icache_pkg::refill_rsp_t             bus_rsp,
    output logic [1:0]                          req_ready,
    output logic [1:0]                          rsp_valid,
    output icache_pkg::refill_rsp_t             rsp,
    output logic                                bus_req_valid,
    output icache_pkg::refill_req_t             bus_req,
    output logic                                bus_rsp_ready
);
    import icache_pkg::*;

    // busy locks the owner, sent marks the request as taken
    logic busy;
    logic sent;
    logic owner;
    logic prio;
    logic sel;
    logic req_phase;

    // favored hart first, otherwise whoever asks
    always_comb begin
        if (busy) begin
            sel = owner;
        end else if (req_valid[prio]) begin
            sel = prio;
        end else begin
            sel = ~prio;
        end
    end

    assign req_phase     = !busy || !sent;
    assign bus_req_valid = req_phase && req_valid[sel];
    assign bus_req       = req[sel];
    assign bus_rsp_ready = busy && sent && rsp_ready[owner];
    assign rsp           = bus_rsp;

    always_comb begin
        req_ready      = '0;
        rsp_valid      = '0;
        req_ready[sel] = req_phase && bus_req_ready;
        rsp_valid[owner] = busy && sent && bus_rsp_valid;
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            busy  <= 1'b0;
            sent  <= 1'b0;
            owner <= 1'b0;
            prio  <= 1'b0;
        end else if (!busy) begin
            // grant is held from the first request cycle
            if (bus_req_valid) begin
                busy  <= 1'b1;
                owner <= sel;
                sent  <= bus_req_ready;
            end
        end else if (!sent) begin
            if (bus_req_valid && bus_req_ready) begin
                sent <= 1'b1;
            end
        end else if (bus_rsp_valid && bus_rsp_ready) begin
            busy <= 1'b0;
            sent <= 1'b0;
            prio <= ~owner;
        end
    end

    // memory answers only a request that was taken
    a_no_idle_rsp: assert property (
        @(posedge clk) disable iff (!rst)
        bus_rsp_valid |-> (busy && sent)
    ) else $error("refill response with no request outstanding");

endmodule

// ==== verilog/icache_top.sv ====
// two-hart fetch subsystem, per-hart controller and array, shared refill arbiter
`timescale 1ns/1ps

module icache_top #(
    parameter int sets = 64
) (
    input  logic                                              clk,
    input  logic                                              rst,
    input  logic [1:0]                                        rena,
    input  logic [1:0][icache_pkg::addr_w-1:0]                pc,
    input  logic                                              bus_req_ready,
    input  logic                                              bus_rsp_valid,
    input  icache_pkg::refill_rsp_t                           bus_rsp,
    output logic [1:0]                                        rdone,
    output logic [1:0]                                        stall,
    output logic [1:0][icache_pkg::words_per_line-1:0][31:0]  inst,
    output logic [1:0][2:0]                                   inst_size,
    output logic                                              bus_req_valid,
    output icache_pkg::refill_req_t                           bus_req,
    output logic                                              bus_rsp_ready
);
    import icache_pkg::*;

    // controller to array
    logic [1:0]                lookup_en;
    logic [1:0]                hit;
    logic [1:0]                lru_way;
    logic [1:0]                wr_en;
    logic [1:0][addr_w-1:0]    wr_pc;
    logic [1:0]                wr_way;
    refill_rsp_t [1:0]         wr_line;

    // controller to arbiter
    logic [1:0]                req_valid;
    logic [1:0]                req_ready;
    refill_req_t [1:0]         req;
    logic [1:0]                rsp_valid;
    logic [1:0]                rsp_ready;
    refill_rsp_t               rsp;

    for (genvar h = 0; h < 2; h++) begin : g_hart
        icache_ctrl #(
            .sets(sets)
        ) u_ctrl (
            .clk       (clk),
            .rst       (rst),
            .rena      (rena[h]),
            .pc        (pc[h]),
            .hit       (hit[h]),
            .lru_way   (lru_way[h]),
            .req_ready (req_ready[h]),
            .rsp_valid (rsp_valid[h]),
            .rsp       (rsp),
            .rdone     (rdone[h]),
            .stall     (stall[h]),
            .lookup_en (lookup_en[h]),
            .wr_en     (wr_en[h]),
            .wr_pc     (wr_pc[h]),
            .wr_way    (wr_way[h]),
            .wr_line   (wr_line[h]),
            .req_valid (req_valid[h]),
            .req       (req[h]),
            .rsp_ready (rsp_ready[h])
        );

        icache_array #(
            .sets(sets)
        ) u_array (
            .clk       (clk),
            .rst       (rst),
            .lookup_pc (pc[h]),
            .lookup_en (lookup_en[h]),
            .wr_en     (wr_en[h]),
            .wr_pc     (wr_pc[h]),
            .wr_way    (wr_way[h]),
            .wr_line   (wr_line[h]),
            .hit       (hit[h]),
            .lru_way   (lru_way[h]),
            .inst      (inst[h]),
            .inst_size (inst_size[h])
        );
    end

    refill_arbiter u_arbiter (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req           (req),
        .rsp_ready     (rsp_ready),
        .bus_req_ready (bus_req_ready),
        .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp       (bus_rsp),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .bus_req_valid (bus_req_valid),
        .bus_req       (bus_req),
        .bus_rsp_ready (bus_rsp_ready)
    );

endmodule

// ==== sim/refill_mem.sv ====
// refill bus memory model with random request and response delays
`timescale 1ns/1ps

module refill_mem #(
    parameter logic [31:0] key = 32'h0,
    parameter int max_delay = 5
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  icache_pkg::refill_req_t  req,
    output logic                     req_ready,
    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output icache_pkg::refill_rsp_t  rsp
);
    import icache_pkg::*;

    logic                     pending;
    logic [addr_w-off_w-1:0]  held_line;
    int                       req_cnt;
    int                       req_dly;
    int                       rsp_cnt;
    int                       rsp_dly;

    // each word is its byte address mixed with the key
    function automatic refill_rsp_t line_data(input logic [addr_w-off_w-1:0] line);
        refill_rsp_t d;
        logic [addr_w-1:0] a;
        for (int w = 0; w < words_per_line; w++) begin
            a = {line, {off_w{1'b0}}} + 32'(w * 4);
            d.data[w*32 +: 32] = a ^ key;
        end
        return d;
    endfunction

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_ready <= 1'b0;
            rsp_valid <= 1'b0;
            rsp       <= '0;
            pending   <= 1'b0;
            held_line <= '0;
            req_cnt   <= 0;
            req_dly   <= 0;
            rsp_cnt   <= 0;
            rsp_dly   <= 0;
        end else if (req_valid && req_ready) begin
            // request taken, draw both delays for the next round
            req_ready <= 1'b0;
            pending   <= 1'b1;
            held_line <= req.line_addr;
            req_cnt   <= 0;
            req_dly   <= int'($urandom_range(max_delay, 0));
            rsp_cnt   <= 0;
            rsp_dly   <= int'($urandom_range(max_delay, 0));
        end else if (rsp_valid && rsp_ready) begin
            rsp_valid <= 1'b0;
            pending   <= 1'b0;
        end else if (pending && !rsp_valid) begin
            if (rsp_cnt >= rsp_dly) begin
                rsp_valid <= 1'b1;
                rsp       <= line_data(held_line);
            end else begin
                rsp_cnt <= rsp_cnt + 1;
            end
        end else if (!pending && req_valid && !req_ready) begin
            if (req_cnt >= req_dly) begin
                req_ready <= 1'b1;
            end else begin
                req_cnt <= req_cnt + 1;
            end
        end
    end

endmodule

// ==== sim/tb_icache_top.sv ====
// testbench with random fetch stimulus, per-hart LRU cache model and refill bus checks
`timescale 1ns/1ps

module tb_icache_top;
    import icache_pkg::*;

    localparam int sets = 8;
    localparam int idx_w = $clog2(sets);
    localparam int fetches = 300;
    localparam int max_delay = 5;
    localparam int hart_bit = 20;
    localparam logic [31:0] pattern_key = 32'h5ec0_1d3a;
    // own refill plus one refill of the other hart queued ahead
    localparam int worst_miss = 2 * (2 * (max_delay + 2) + 2);
    localparam int timeout_cycles = fetches * (worst_miss + 2) + 100;

    logic                                    clk;
    logic                                    rst;
    logic [1:0]                              rena;
    logic [1:0][addr_w-1:0]                  pc;
    logic [1:0]                              rdone;
    logic [1:0]                              stall;
    logic [1:0][words_per_line-1:0][31:0]    inst;
    logic [1:0][2:0]                         inst_size;
    logic                                    bus_req_valid;
    logic                                    bus_req_ready;
    refill_req_t                             bus_req;
    logic                                    bus_rsp_valid;
    logic                                    bus_rsp_ready;
    refill_rsp_t                             bus_rsp;

    // cache model indexed by hart, set and way
    logic [addr_w-off_w-1:0]  m_line [2][sets][2];
    logic                     m_valid [2][sets][2];
    logic                     m_lru [2][sets];
    int                       req_seen [2];
    logic [addr_w-off_w-1:0]  req_line [2];
    logic                     outstanding;
    int                       cycle_cnt;

    // expected hit pattern for three lines sharing one set
    int   prefix_tag [6] = '{0, 1, 0, 2, 0, 1};
    logic prefix_hit [6] = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0};

    icache_top #(
        .sets(sets)
    ) dut (
        .clk           (clk),
        .rst           (rst),
        .rena          (rena),
        .pc            (pc),
        .bus_req_ready (bus_req_ready),
        .bus_rsp_valid (bus_rsp_valid),
        .bus_rsp       (bus_rsp),
        .rdone         (rdone),
        .stall         (stall),
        .inst          (inst),
        .inst_size     (inst_size),
        .bus_req_valid (bus_req_valid),
        .bus_req       (bus_req),
        .bus_rsp_ready (bus_rsp_ready)
    );

    refill_mem #(
        .key       (pattern_key),
        .max_delay (max_delay)
    ) u_mem (
        .clk       (clk),
        .rst       (rst),
        .req_valid (bus_req_valid),
        .req       (bus_req),
        .req_ready (bus_req_ready),
        .rsp_valid (bus_rsp_valid),
        .rsp_ready (bus_rsp_ready),
        .rsp       (bus_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [line_w-1:0] expected,
                               input logic [line_w-1:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s: expected %h actual %h", name, expected, actual);
            stop_run("a DUT output differed from the model");
        end
    endtask

    function automatic logic [addr_w-1:0] pool_addr(input int h, input int tag,
                                                    input int set, input int word);
        return (32'(h) << hart_bit) | (32'(tag) << (off_w + idx_w)) |
               (32'(set) << off_w) | (32'(word) << 2);
    endfunction

    // way holding the line or -1 on a miss
    function automatic int model_find(input int h, input logic [addr_w-1:0] a);
        int idx;
        int way;
        idx = int'(a[off_w +: idx_w]);
        way = -1;
        for (int w = 0; w < 2; w++) begin
            if (m_valid[h][idx][w] && (m_line[h][idx][w] == a[addr_w-1:off_w])) begin
                way = w;
            end
        end
        return way;
    endfunction

    function automatic void model_update(input int h, input logic [addr_w-1:0] a, input int way);
        int idx;
        logic victim;
        idx = int'(a[off_w +: idx_w]);
        if (way >= 0) begin
            m_lru[h][idx] = (way == 0);
        end else begin
            victim = m_lru[h][idx];
            m_line[h][idx][victim] = a[addr_w-1:off_w];
            m_valid[h][idx][victim] = 1'b1;
            m_lru[h][idx] = ~victim;
        end
    endfunction

    // words from pc to the end of the line and zero beyond
    function automatic logic [line_w-1:0] expected_inst(input logic [addr_w-1:0] a);
        logic [line_w-1:0] v;
        logic [addr_w-1:0] wa;
        int wofs;
        v = '0;
        wofs = int'(a[off_w-1:2]);
        for (int i = 0; i < words_per_line; i++) begin
            if (i + wofs < words_per_line) begin
                wa = {a[addr_w-1:2], 2'b00} + 32'(i * 4);
                v[i*32 +: 32] = wa ^ pattern_key;
            end
        end
        return v;
    endfunction

    task automatic run_hart(input int h);
        logic [addr_w-1:0] a;
        logic predicted_hit;
        int way;
        int wofs;
        string where;
        for (int n = 0; n < fetches; n++) begin
            if (n < 6) begin
                a = pool_addr(h, prefix_tag[n], 3, int'($urandom_range(3, 0)));
            end else begin
                a = pool_addr(h, int'($urandom_range(2, 0)), int'($urandom_range(3, 0)),
                              int'($urandom_range(3, 0)));
            end
            where = $sformatf("hart %0d pc %h", h, a);
            way = model_find(h, a);
            predicted_hit = (way >= 0);
            wofs = int'(a[off_w-1:2]);
            @(posedge clk);
            rena[h] <= 1'b1;
            pc[h]   <= a;
            req_seen[h] = 0;
            @(negedge clk);
            if (n < 6) begin
                check_value({"lru order ", where}, line_w'(prefix_hit[n]), line_w'(rdone[h]));
            end
            check_value({"first cycle rdone ", where}, line_w'(predicted_hit), line_w'(rdone[h]));
            check_value({"first cycle stall ", where}, line_w'(!predicted_hit), line_w'(stall[h]));
            while (!rdone[h]) begin
                @(negedge clk);
                if (!rdone[h]) begin
                    check_value({"stall during miss ", where}, line_w'(1), line_w'(stall[h]));
                end
            end
            check_value({"stall at rdone ", where}, line_w'(0), line_w'(stall[h]));
            check_value({"inst ", where}, expected_inst(a), line_w'(inst[h]));
            check_value({"inst_size ", where}, line_w'(4 - wofs), line_w'(inst_size[h]));
            check_value({"refill count ", where}, line_w'(predicted_hit ? 0 : 1),
                        line_w'(req_seen[h]));
            if (!predicted_hit) begin
                check_value({"refill line ", where}, line_w'(a[addr_w-1:off_w]),
                            line_w'(req_line[h]));
            end
            model_update(h, a, way);
            // occasional idle cycle between fetches
            if ($urandom_range(3, 0) == 0) begin
                @(posedge clk);
                rena[h] <= 1'b0;
            end
        end
        @(posedge clk);
        rena[h] <= 1'b0;
    endtask

    // bus transfers are sampled mid-cycle and take effect at the next edge
    always @(negedge clk) begin
        int owner;
        if (rst) begin
            if (bus_rsp_valid && bus_rsp_ready) begin
                outstanding = 1'b0;
            end
            if (bus_req_valid && bus_req_ready) begin
                if (outstanding) begin
                    stop_run("second refill request accepted before the previous response");
                end
                outstanding = 1'b1;
                owner = int'(bus_req.line_addr[hart_bit - off_w]);
                req_seen[owner] = req_seen[owner] + 1;
                req_line[owner] = bus_req.line_addr;
            end
        end
    end

    always @(posedge clk or negedge rst) begin
        if (!rst) begin
            cycle_cnt <= 0;
        end else begin
            cycle_cnt <= cycle_cnt + 1;
            if (cycle_cnt > timeout_cycles) begin
                stop_run($sformatf("timeout after %0d cycles", cycle_cnt));
            end
        end
    end

    initial begin
        void'($urandom(32'h4a35));
        rst = 1'b0;
        rena = '0;
        pc = '0;
        outstanding = 1'b0;
        for (int h = 0; h < 2; h++) begin
            req_seen[h] = 0;
            req_line[h] = '0;
            for (int s = 0; s < sets; s++) begin
                m_lru[h][s] = 1'b0;
                m_valid[h][s][0] = 1'b0;
                m_valid[h][s][1] = 1'b0;
            end
        end
        repeat (4) @(posedge clk);
        rst <= 1'b1;
        @(negedge clk);
        check_value("rdone after reset", line_w'(0), line_w'(rdone));
        check_value("stall after reset", line_w'(0), line_w'(stall));
        check_value("bus_req_valid after reset", line_w'(0), line_w'(bus_req_valid));
        check_value("bus_rsp_ready after reset", line_w'(0), line_w'(bus_rsp_ready));
        fork
            run_hart(0);
            run_hart(1);
        join
        repeat (2) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== sources.f ====
verilog/icache_pkg.sv
verilog/icache_array.sv
verilog/icache_ctrl.sv
verilog/refill_arbiter.sv
verilog/icache_top.sv
sim/refill_mem.sv
sim/tb_icache_top.sv

// ==== Makefile ====
TOP := tb_icache_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f sources.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) \
		-Mdir obj_dir -o sim_$(TOP)
	./obj_dir/sim_$(TOP)

clean:
	rm -rf obj_dir
